// File: filelist.f
hw/cop_pkg.sv
hw/cop_idecode.sv
hw/cop_regfile.sv
hw/cop_palu.sv
hw/cop_apb_ctrl.sv
hw/cop_top.sv
sim/tb_cop.sv

// File: hw/cop_apb_ctrl.sv
// ========================================
// APB slave for the coprocessor
// Instruction issue, register access,
// write-back and the status word
// ========================================
`timescale 1ns/1ps
`default_nettype none

module cop_apb_ctrl (
    input  logic                        g_clk_i,
    input  logic                        reset_i,
    input  logic [cop_pkg::APB_AW-1:0]  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  cop_pkg::cop_word_t          pwdata_i,
    output cop_pkg::cop_word_t          prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output cop_pkg::cop_word_t          instr_o,
    input  cop_pkg::cop_dec_t           dec_i,
    output cop_pkg::creg_idx_t          rs_a_idx_o,
    input  cop_pkg::cop_word_t          rs_a_data_i,
    input  cop_pkg::cop_word_t          result_i,
    output logic                        wr_en_o,
    output cop_pkg::creg_idx_t          wr_idx_o,
    output cop_pkg::cop_word_t          wr_data_o
);

    cop_pkg::cop_word_t instr_q;
    cop_pkg::cop_word_t status_word;
    cop_pkg::creg_idx_t creg_idx;
    cop_pkg::creg_idx_t last_crd_q;
    logic               issue_q;     // Second access cycle of an instruction write
    logic               illegal_q;
    logic               access;
    logic               is_instr;
    logic               is_status;
    logic               is_creg;
    logic               instr_wr;
    logic               addr_err;

    assign access    = psel_i && penable_i;
    assign is_instr  = (paddr_i == cop_pkg::ADDR_INSTR);
    assign is_status = (paddr_i == cop_pkg::ADDR_STATUS);
    assign is_creg   = (paddr_i[cop_pkg::APB_AW-1:6]
                        == cop_pkg::ADDR_CREG_BASE[cop_pkg::APB_AW-1:6])
                       && (paddr_i[1:0] == 2'b00);
    assign creg_idx  = paddr_i[5:2];
    assign instr_wr  = is_instr && pwrite_i;
    // Instruction is write only, status is read only
    assign addr_err  = !(instr_wr || (is_status && !pwrite_i) || is_creg);

    always_ff @(posedge g_clk_i) begin
        if (reset_i) begin
            issue_q    <= 1'b0;
            illegal_q  <= 1'b0;
            last_crd_q <= '0;
        end else begin
            issue_q <= access && instr_wr && !issue_q;
            if (issue_q) begin
                illegal_q <= dec_i.exception;
                if (!dec_i.exception) last_crd_q <= dec_i.crd;
            end
        end
    end

    always_ff @(posedge g_clk_i) begin
        if (access && instr_wr && !issue_q) instr_q <= pwdata_i;
    end

    always_comb begin
        status_word = '0;
        status_word[cop_pkg::STATUS_ILLEGAL_BIT]  = illegal_q;
        status_word[cop_pkg::STATUS_CRD_LSB +: 4] = last_crd_q;
    end

    assign instr_o    = instr_q;
    assign pready_o   = access && (!instr_wr || issue_q);
    assign pslverr_o  = pready_o && (addr_err || (issue_q && dec_i.exception));
    assign prdata_o   = is_status ? status_word : (is_creg ? rs_a_data_i : '0);

    // Port A serves the executing instruction or the host
    assign rs_a_idx_o = issue_q ? dec_i.crs1 : creg_idx;
    assign wr_en_o    = access && (issue_q ? !dec_i.exception : (pwrite_i && is_creg));
    assign wr_idx_o   = issue_q ? dec_i.crd : creg_idx;
    assign wr_data_o  = issue_q ? result_i : pwdata_i;

    // Issue phase relies on the same transfer still being on the bus
    a_hold_in_wait: assert property (
        @(posedge g_clk_i) disable iff (reset_i)
        access && !pready_o |=> access && $stable(paddr_i) && $stable(pwrite_i)
    ) else $error("cop_apb_ctrl: transfer changed during a wait state");

endmodule

`default_nettype wire

// File: hw/cop_idecode.sv
// ========================================
// Coprocessor instruction decoder
// Combinational, word in and decoded
// struct out, with the illegal check
// ========================================
`timescale 1ns/1ps
`default_nettype none

module cop_idecode (
    input  cop_pkg::cop_word_t instr_i,
    output cop_pkg::cop_dec_t  dec_o
);

    cop_pkg::cop_funct_e funct;
    cop_pkg::pw_e        pw;
    cop_pkg::creg_idx_t  crd;
    cop_pkg::iclass_e    iclass;
    cop_pkg::sclass_e    sclass;
    logic                opcode_ok;
    logic                funct_ok;
    logic                is_li;
    logic                is_shift;
    logic                bad_pw;
    logic                exception;

    assign funct     = cop_pkg::cop_funct_e'(instr_i[cop_pkg::FLD_FUNCT_LSB +: 4]);
    assign pw        = cop_pkg::pw_e'(instr_i[cop_pkg::FLD_PW_LSB +: 3]);
    assign crd       = instr_i[cop_pkg::FLD_CRD_LSB +: 4];
    assign opcode_ok = (instr_i[6:0] == cop_pkg::COP_OPCODE);

    // Class and subclass per funct code
    always_comb begin
        funct_ok = 1'b1;
        is_li    = 1'b0;
        is_shift = 1'b0;
        iclass   = cop_pkg::ICLASS_NONE;
        sclass   = cop_pkg::SCLASS_PADD;
        case (funct)
            cop_pkg::FN_PADD: begin
                iclass = cop_pkg::ICLASS_PACKED_ARITH;
                sclass = cop_pkg::SCLASS_PADD;
            end
            cop_pkg::FN_PSUB: begin
                iclass = cop_pkg::ICLASS_PACKED_ARITH;
                sclass = cop_pkg::SCLASS_PSUB;
            end
            cop_pkg::FN_PSLL_I: begin
                iclass   = cop_pkg::ICLASS_PACKED_ARITH;
                sclass   = cop_pkg::SCLASS_PSLL_I;
                is_shift = 1'b1;
            end
            cop_pkg::FN_PSRL_I: begin
                iclass   = cop_pkg::ICLASS_PACKED_ARITH;
                sclass   = cop_pkg::SCLASS_PSRL_I;
                is_shift = 1'b1;
            end
            cop_pkg::FN_LD_LIU: begin
                iclass = cop_pkg::ICLASS_BITWISE;
                sclass = cop_pkg::SCLASS_LD_LIU;
                is_li  = 1'b1;
            end
            cop_pkg::FN_LD_HIU: begin
                iclass = cop_pkg::ICLASS_BITWISE;
                sclass = cop_pkg::SCLASS_LD_HIU;
                is_li  = 1'b1;
            end
            cop_pkg::FN_MV: begin
                iclass = cop_pkg::ICLASS_MOVE;
                sclass = cop_pkg::SCLASS_MV;
            end
            default: funct_ok = 1'b0;
        endcase
    end

    assign bad_pw    = (iclass == cop_pkg::ICLASS_PACKED_ARITH) && (pw > cop_pkg::PW_2);
    assign exception = !opcode_ok || !funct_ok || bad_pw;

    always_comb begin
        dec_o           = '0;
        dec_o.exception = exception;
        dec_o.iclass    = exception ? cop_pkg::ICLASS_NONE : iclass;
        dec_o.subclass  = sclass;
        dec_o.pw        = pw;
        dec_o.crs1      = instr_i[cop_pkg::FLD_CRS1_LSB +: 4];
        // Load-immediate keeps the other half of crd, so crd is read as a source
        dec_o.crs2      = is_li ? crd : instr_i[cop_pkg::FLD_CRS2_LSB +: 4];
        dec_o.crd       = crd;
        if (is_shift) begin
            dec_o.imm = {27'b0, instr_i[cop_pkg::FLD_SHAMT_LSB +: 5]};
        end else if (is_li) begin
            dec_o.imm = {16'b0, instr_i[cop_pkg::FLD_IMM16_LSB +: 16]};
        end
    end

endmodule

`default_nettype wire

// File: hw/cop_palu.sv
// ========================================
// Packed lane execution unit
// Add, sub, shifts, load-imm and move
// ========================================
`timescale 1ns/1ps
`default_nettype none

module cop_palu (
    input  cop_pkg::cop_dec_t  dec_i,
    input  cop_pkg::cop_word_t rs1_i,
    input  cop_pkg::cop_word_t rs2_i,
    output cop_pkg::cop_word_t result_o
);

    localparam int NUM_PW = 5;   // 32, 16, 8, 4 and 2 bit lanes

    wire cop_pkg::cop_word_t padd_w [NUM_PW];
    wire cop_pkg::cop_word_t psub_w [NUM_PW];
    wire cop_pkg::cop_word_t psll_w [NUM_PW];
    wire cop_pkg::cop_word_t psrl_w [NUM_PW];
    logic [2:0]              pw_idx;

    // One set of lanes per pack width, no carry between lanes
    for (genvar w = 0; w < NUM_PW; w++) begin : g_pw
        localparam int LW = 32 >> w;
        localparam int SW = $clog2(LW);
        for (genvar l = 0; l < 32 / LW; l++) begin : g_lane
            assign padd_w[w][l*LW +: LW] = rs1_i[l*LW +: LW] + rs2_i[l*LW +: LW];
            assign psub_w[w][l*LW +: LW] = rs1_i[l*LW +: LW] - rs2_i[l*LW +: LW];
            // Amount taken modulo the lane width
            assign psll_w[w][l*LW +: LW] = rs1_i[l*LW +: LW] << dec_i.imm[SW-1:0];
            assign psrl_w[w][l*LW +: LW] = rs1_i[l*LW +: LW] >> dec_i.imm[SW-1:0];
        end
    end

    // Reserved widths never retire, keep the index in range
    assign pw_idx = (dec_i.pw > cop_pkg::PW_2) ? 3'd0 : dec_i.pw;

    always_comb begin
        result_o = '0;
        case (dec_i.iclass)
            cop_pkg::ICLASS_PACKED_ARITH: begin
                case (dec_i.subclass)
                    cop_pkg::SCLASS_PADD:   result_o = padd_w[pw_idx];
                    cop_pkg::SCLASS_PSUB:   result_o = psub_w[pw_idx];
                    cop_pkg::SCLASS_PSLL_I: result_o = psll_w[pw_idx];
                    cop_pkg::SCLASS_PSRL_I: result_o = psrl_w[pw_idx];
                    default:                result_o = '0;
                endcase
            end
            cop_pkg::ICLASS_BITWISE: begin
                if (dec_i.subclass == cop_pkg::SCLASS_LD_HIU) begin
                    result_o = {dec_i.imm[15:0], rs2_i[15:0]};
                end else begin
                    result_o = {rs2_i[31:16], dec_i.imm[15:0]};   // Low half load
                end
            end
            cop_pkg::ICLASS_MOVE: result_o = rs1_i;
            default:              result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cop_pkg.sv
// ========================================
// Coprocessor shared definitions
// Instruction encoding, decode types and
// the APB register map
// ========================================
`default_nettype none

package cop_pkg;

    typedef logic [31:0] cop_word_t;
    typedef logic [3:0]  creg_idx_t;

    localparam int NUM_CREGS = 16;

    // Major opcode, custom-2 space
    localparam logic [6:0] COP_OPCODE = 7'b1011011;

    // Field positions within the instruction word
    localparam int FLD_CRD_LSB   = 8;
    localparam int FLD_CRS1_LSB  = 12;
    localparam int FLD_CRS2_LSB  = 16;
    localparam int FLD_PW_LSB    = 20;
    localparam int FLD_SHAMT_LSB = 23;   // 5 bits
    localparam int FLD_FUNCT_LSB = 28;
    localparam int FLD_IMM16_LSB = 12;   // Load-immediate value, bits 27:12

    typedef enum logic [3:0] {
        FN_PADD   = 4'd0,
        FN_PSUB   = 4'd1,
        FN_PSLL_I = 4'd2,
        FN_PSRL_I = 4'd3,
        FN_LD_LIU = 4'd4,
        FN_LD_HIU = 4'd5,
        FN_MV     = 4'd6
    } cop_funct_e;

    typedef enum logic [3:0] {
        ICLASS_NONE         = 4'd0,
        ICLASS_PACKED_ARITH = 4'd1,
        ICLASS_BITWISE      = 4'd2,
        ICLASS_MOVE         = 4'd3
    } iclass_e;

    typedef enum logic [4:0] {
        SCLASS_PADD   = 5'd0,
        SCLASS_PSUB   = 5'd1,
        SCLASS_PSLL_I = 5'd2,
        SCLASS_PSRL_I = 5'd3,
        SCLASS_LD_LIU = 5'd4,
        SCLASS_LD_HIU = 5'd5,
        SCLASS_MV     = 5'd6
    } sclass_e;

    // Codes 5 to 7 are reserved
    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2,
        PW_4  = 3'd3,
        PW_2  = 3'd4
    } pw_e;

    typedef struct packed {
        logic      exception;
        iclass_e   iclass;
        sclass_e   subclass;
        pw_e       pw;
        creg_idx_t crs1;
        creg_idx_t crs2;
        creg_idx_t crd;
        cop_word_t imm;
    } cop_dec_t;

    localparam int APB_AW = 12;
    localparam logic [APB_AW-1:0] ADDR_INSTR     = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_STATUS    = 12'h004;
    localparam logic [APB_AW-1:0] ADDR_CREG_BASE = 12'h040;

    localparam int STATUS_ILLEGAL_BIT = 0;
    localparam int STATUS_CRD_LSB     = 8;

endpackage

`default_nettype wire

// File: hw/cop_regfile.sv
// ========================================
// Coprocessor register file
// c0 to c15, two async reads, one write
// ========================================
`timescale 1ns/1ps
`default_nettype none

module cop_regfile (
    input  logic               g_clk_i,
    input  logic               reset_i,
    input  cop_pkg::creg_idx_t rd_idx_a_i,
    input  cop_pkg::creg_idx_t rd_idx_b_i,
    output cop_pkg::cop_word_t rd_data_a_o,
    output cop_pkg::cop_word_t rd_data_b_o,
    input  logic               wr_en_i,
    input  cop_pkg::creg_idx_t wr_idx_i,
    input  cop_pkg::cop_word_t wr_data_i
);

    cop_pkg::cop_word_t regs_q [cop_pkg::NUM_CREGS];

    always_ff @(posedge g_clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < cop_pkg::NUM_CREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    assign rd_data_a_o = regs_q[rd_idx_a_i];
    assign rd_data_b_o = regs_q[rd_idx_b_i];   // Old crd for load-immediate

    // X on write data would poison the register for every later read
    a_wr_data_known: assert property (
        @(posedge g_clk_i) disable iff (reset_i)
        wr_en_i |-> !$isunknown(wr_data_i)
    ) else $error("cop_regfile: unknown write data");

endmodule

`default_nettype wire

// File: hw/cop_top.sv
// ========================================
// Coprocessor slice top level
// APB front end, decoder, registers, ALU
// ========================================
`timescale 1ns/1ps
`default_nettype none

module cop_top (
    input  logic                        g_clk_i,
    input  logic                        reset_i,
    input  logic [cop_pkg::APB_AW-1:0]  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  cop_pkg::cop_word_t          pwdata_i,
    output cop_pkg::cop_word_t          prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);

    cop_pkg::cop_word_t instr;
    cop_pkg::cop_dec_t  dec;
    cop_pkg::creg_idx_t rs_a_idx;
    cop_pkg::cop_word_t rs_a_data;
    cop_pkg::cop_word_t rs_b_data;
    cop_pkg::cop_word_t result;
    logic               wr_en;
    cop_pkg::creg_idx_t wr_idx;
    cop_pkg::cop_word_t wr_data;

    cop_apb_ctrl i_ctrl (
        .g_clk_i    (g_clk_i),   .reset_i    (reset_i),
        .paddr_i    (paddr_i),   .psel_i     (psel_i),
        .penable_i  (penable_i), .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),  .prdata_o   (prdata_o),
        .pready_o   (pready_o),  .pslverr_o  (pslverr_o),
        .instr_o    (instr),     .dec_i      (dec),
        .rs_a_idx_o (rs_a_idx),  .rs_a_data_i(rs_a_data),
        .result_i   (result),    .wr_en_o    (wr_en),
        .wr_idx_o   (wr_idx),    .wr_data_o  (wr_data)
    );

    cop_idecode i_idecode (.instr_i(instr), .dec_o(dec));

    cop_regfile i_regfile (
        .g_clk_i    (g_clk_i),   .reset_i    (reset_i),
        .rd_idx_a_i (rs_a_idx),  .rd_idx_b_i (dec.crs2),   // Port B always follows crs2
        .rd_data_a_o(rs_a_data), .rd_data_b_o(rs_b_data),
        .wr_en_i    (wr_en),     .wr_idx_i   (wr_idx),
        .wr_data_i  (wr_data)
    );

    cop_palu i_palu (.dec_i(dec), .rs1_i(rs_a_data), .rs2_i(rs_b_data), .result_o(result));

endmodule

`default_nettype wire

// File: sim/cop_testdata.txt
// Columns: kind (W write, R read), APB address, write data or expected read data,
// expected pslverr. Instruction writes go to address 000.
R 040 00000000 0
W 044 80FF7F01 0
W 048 80017F01 0
R 044 80FF7F01 0
W 000 0022135B 0
R 04C 0000FE02 0
W 000 1011255B 0
R 054 FF020000 0
W 000 0032175B 0
R 05C 00F0EE02 0
W 000 0042185B 0
R 060 00FCAA02 0
W 000 1002165B 0
R 058 00FE0000 0
W 000 24A0195B 0
R 064 00FEFE02 0
W 000 3A101A5B 0
R 068 080F07F0 0
W 000 4BEEF15B 0
W 000 5CAFE15B 0
W 000 60001B5B 0
R 06C CAFEBEEF 0
W 000 0022135A 1
R 004 00000B01 0
W 000 7002135B 1
W 000 0052135B 1
R 04C 0000FE02 0
W 000 60002C5B 0
R 004 00000C00 0
R 008 00000000 1

// File: sim/tb_cop.sv
// ========================================
// Testbench for the coprocessor slice
// Replays APB transfers from a data file
// and checks read data and pslverr
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_cop;

    typedef struct packed {
        logic                       is_write;
        logic [cop_pkg::APB_AW-1:0] addr;
        cop_pkg::cop_word_t         data;   // Write data or expected read data
        logic                       err;
    } txn_t;

    logic                       clk;
    logic                       reset;
    logic [cop_pkg::APB_AW-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    cop_pkg::cop_word_t         pwdata;
    cop_pkg::cop_word_t         prdata;
    logic                       pready;
    logic                       pslverr;

    txn_t        txns [$];
    logic [31:0] lfsr_state  = 32'h8b71581a;
    int          cycle_cnt   = 0;
    int          cycle_limit = 100;   // Raised once the records are loaded

    cop_top i_dut (
        .g_clk_i   (clk),
        .reset_i   (reset),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Simulation timed out after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic idle_gap();
        int gap;
        gap = 0;
        repeat (2) begin
            gap        = (gap << 1) | lfsr_state[31];
            lfsr_state = lfsr_next(lfsr_state);
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Starts 1 ns after an edge, ends 1 ns after the completing edge
    task automatic bus_transfer(input logic wr, input logic [cop_pkg::APB_AW-1:0] addr,
                                input cop_pkg::cop_word_t wdata,
                                output cop_pkg::cop_word_t rdata, output logic err,
                                output int waits);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin   // Wait states
            waits = waits + 1;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [cop_pkg::APB_AW-1:0] addr,
                             input cop_pkg::cop_word_t data, output logic err,
                             output int waits);
        cop_pkg::cop_word_t unused;
        bus_transfer(1'b1, addr, data, unused, err, waits);
    endtask

    task automatic apb_read(input logic [cop_pkg::APB_AW-1:0] addr,
                            output cop_pkg::cop_word_t data, output logic err,
                            output int waits);
        bus_transfer(1'b0, addr, '0, data, err, waits);
    endtask

    task automatic check_word(input cop_pkg::cop_word_t got, input cop_pkg::cop_word_t exp,
                              input int rec);
        if (got !== exp) begin
            $display("ERROR at %0t ns: record %0d read data %08h, expected %08h",
                     $time, rec, got, exp);
            $display("Testbench failed");
            $fatal(1, "Read data mismatch");
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input int rec);
        if (got !== exp) begin
            $display("ERROR at %0t ns: record %0d pslverr %b, expected %b",
                     $time, rec, got, exp);
            $display("Testbench failed");
            $fatal(1, "pslverr mismatch");
        end
    endtask

    task automatic check_waits(input int got, input int exp, input int rec);
        if (got != exp) begin
            $display("ERROR at %0t ns: record %0d took %0d wait states, expected %0d",
                     $time, rec, got, exp);
            $display("Testbench failed");
            $fatal(1, "Wait state mismatch");
        end
    endtask

    task automatic load_txns();
        int                         fd;
        int                         n;
        string                      line;
        logic [7:0]                 kind;
        logic [cop_pkg::APB_AW-1:0] addr;
        logic [31:0]                data;
        logic                       err;
        txn_t                       t;
        fd = $fopen("sim/cop_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file sim/cop_testdata.txt");
            $display("Testbench failed");
            $fatal(1, "No test data");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() >= 2 && line.getc(0) != "/") begin   // Skip blanks and comments
                    n = $sscanf(line, "%c %h %h %h", kind, addr, data, err);
                    if (n != 4 || (kind != "W" && kind != "R")) begin
                        $display("Malformed test data line: %s", line);
                        $display("Testbench failed");
                        $fatal(1, "Bad test data");
                    end else begin
                        t.is_write = (kind == "W");
                        t.addr     = addr;
                        t.data     = data;
                        t.err      = err;
                        txns.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        cop_pkg::cop_word_t rdata;
        logic               err;
        int                 waits;
        int                 exp_waits;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        load_txns();
        cycle_limit = 20 * txns.size() + 100;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (txns[i]) begin
            if (txns[i].is_write) begin
                apb_write(txns[i].addr, txns[i].data, err, waits);
            end else begin
                apb_read(txns[i].addr, rdata, err, waits);
            end
            // Only an instruction write is held for one wait state
            exp_waits = (txns[i].is_write && txns[i].addr == cop_pkg::ADDR_INSTR) ? 1 : 0;
            check_waits(waits, exp_waits, i + 1);
            check_err(err, txns[i].err, i + 1);
            if (!txns[i].is_write && !txns[i].err) begin
                check_word(rdata, txns[i].data, i + 1);   // Read data only valid without error
            end
            idle_gap();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
